// File: build.f
+incdir+include
hdl/pet_bus_pkg.sv
hdl/pet_seq_pkg.sv
hdl/ram_bus_if.sv
hdl/address_decoder.sv
hdl/bus_slot_sequencer.sv
hdl/wb_ram_port.sv
hdl/pet_system.sv
verif/sram_model.sv
verif/tb_pet_system.sv

// File: hdl/address_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module address_decoder
    import pet_bus_pkg::*;
(
    input  cpu_addr_t addr_i,
    output region_e   region_o
);

    logic io_page;                      // E800-E8FF

    assign io_page = (addr_i[15:8] == 8'he8);

    // PET memory map
    // ROM is its own region, so the sequencer never writes it
    always_comb begin
        if (io_page) begin
            if (addr_i[7:2] == 6'b0001_00) begin
                region_o = PIA1;        // E810-E813
            end else if (addr_i[7:2] == 6'b0010_00) begin
                region_o = PIA2;        // E820-E823
            end else if (addr_i[7:4] == 4'h4) begin
                region_o = VIA;         // E840-E84F
            end else begin
                region_o = IO_OTHER;
            end
        end else if (addr_i < 16'h9000) begin
            region_o = RAM;
        end else begin
            region_o = ROM;             // Image lives in SRAM too
        end
    end

endmodule

`default_nettype wire

// File: hdl/bus_slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_settings.svh"

module bus_slot_sequencer
    import pet_bus_pkg::*;
    import pet_seq_pkg::*;
(
    input  logic    wb_clock_i,
    input  logic    rst_n_i,
    input  region_e region_i,       // Decoded CPU address
    input  logic    cpu_we_i,       // CPU RWB, high for write
    output logic    cpu_be_o,       // CPU bus enable
    output logic    cpu_clock_o,    // Phi2
    output logic    wb_grant_o,     // Wishbone may start a cycle
    output logic    addr_oe_o,      // FPGA drives the CPU address bus
    output logic    cpu_ram_oe_o,   // CPU read of RAM or ROM
    output logic    cpu_ram_we_o,   // CPU write of RAM, aligned to Phi2
    output logic    io_oe_o,        // I/O transceiver enable
    output logic    io_valid_o      // Chip selects may assert
);

    localparam slot_cnt_t READY_END  = '0;
    localparam slot_cnt_t BE_START   = slot_cnt_t'(`BE_START);
    localparam slot_cnt_t BUS_VALID  = slot_cnt_t'(`BUS_VALID);
    localparam slot_cnt_t IO_VALID   = slot_cnt_t'(`IO_VALID);
    localparam slot_cnt_t PHI_START  = slot_cnt_t'(`PHI_START);
    localparam slot_cnt_t PHI_END    = slot_cnt_t'(`PHI_END);
    localparam slot_cnt_t BE_END     = slot_cnt_t'(`BE_END);
    localparam slot_cnt_t WB_ADDR_OE = slot_cnt_t'(`WB_ADDR_OE);
    localparam slot_cnt_t WB_READY   = slot_cnt_t'(`WB_READY);

    slot_cnt_t slot_cnt;
    region_e   region_q;            // Region held from BUS_VALID on
    logic      we_q;                // RWB held from BUS_VALID on
    logic      mem_hit;             // RAM or ROM image
    logic      io_hit;              // Anywhere in the I/O page

    assign mem_hit = (region_i == RAM) || (region_i == ROM);
    assign io_hit  = !mem_hit;

    // Free running, one wrap per CPU cycle
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // CPU address and RWB are stable once the bus is valid
    always_ff @(posedge wb_clock_i) begin
        if (slot_cnt == BUS_VALID) begin
            region_q <= region_i;
            we_q     <= cpu_we_i;
        end
    end

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cpu_be_o     <= 1'b0;
            cpu_clock_o  <= 1'b0;
            wb_grant_o   <= 1'b0;       // Stall until the first WB_READY
            addr_oe_o    <= 1'b0;
            cpu_ram_oe_o <= 1'b0;
            cpu_ram_we_o <= 1'b0;
            io_oe_o      <= 1'b0;
            io_valid_o   <= 1'b0;
        end else begin
            case (slot_cnt)
                READY_END:  wb_grant_o <= 1'b0;     // No new Wishbone cycles
                BE_START: begin                     // Wishbone drained
                    cpu_be_o  <= 1'b1;
                    addr_oe_o <= 1'b0;
                end
                BUS_VALID: begin
                    cpu_ram_oe_o <= mem_hit && !cpu_we_i;
                    io_oe_o      <= io_hit;
                end
                IO_VALID:   io_valid_o <= 1'b1;
                PHI_START: begin
                    cpu_clock_o  <= 1'b1;
                    cpu_ram_we_o <= (region_q == RAM) && we_q;  // ROM stays unwritten
                end
                PHI_END: begin
                    cpu_clock_o  <= 1'b0;
                    cpu_ram_we_o <= 1'b0;
                end
                BE_END: begin                       // CPU heads for high-Z
                    cpu_be_o     <= 1'b0;
                    cpu_ram_oe_o <= 1'b0;
                    io_oe_o      <= 1'b0;
                    io_valid_o   <= 1'b0;
                end
                WB_ADDR_OE: addr_oe_o  <= 1'b1;     // FPGA takes the address bus
                WB_READY:   wb_grant_o <= 1'b1;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/pet_bus_pkg.sv
`default_nettype none

`include "pet_settings.svh"

package pet_bus_pkg;

    typedef logic [`CPU_ADDR_W-1:0] cpu_addr_t;    // Address as the 6502 sees it
    typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;    // SRAM and Wishbone address
    typedef logic [`DATA_W-1:0]     data_t;        // Shared data byte

    // Decoded region of a CPU address
    typedef enum logic [2:0] {
        RAM,        // 0000-8FFF
        ROM,        // 9000-FFFF outside the I/O page, no CPU writes
        PIA1,       // E810-E813
        PIA2,       // E820-E823
        VIA,        // E840-E84F
        IO_OTHER    // Rest of E800-E8FF, transceiver only
    } region_e;

endpackage

`default_nettype wire

// File: hdl/pet_seq_pkg.sv
`default_nettype none

`include "pet_settings.svh"

package pet_seq_pkg;

    // Position inside one CPU slot, wraps every `SLOT_CYCLES clocks
    typedef logic [$clog2(`SLOT_CYCLES)-1:0] slot_cnt_t;

    // Wishbone side of the SRAM
    typedef enum logic [1:0] {
        IDLE,       // Waiting for a strobe inside the grant
        ACCESS,     // SRAM strobes out
        ACK         // One clock ack to the host
    } wb_state_e;

endpackage

`default_nettype wire

// File: hdl/pet_system.sv
`timescale 1ns/1ps
`default_nettype none

module pet_system
    import pet_bus_pkg::*;
(
    input  logic      wb_clock_i,
    input  logic      rst_n_i,

    // Wishbone B4 pipelined, host side
    input  ram_addr_t wb_addr_i,
    input  data_t     wb_data_i,
    output data_t     wb_data_o,
    input  logic      wb_we_i,
    input  logic      wb_cycle_i,
    input  logic      wb_strobe_i,
    output logic      wb_stall_o,
    output logic      wb_ack_o,

    // 6502
    output logic      cpu_be_o,
    output logic      cpu_clock_o,  // Phi2
    input  logic      cpu_we_i,
    input  cpu_addr_t cpu_addr_i,
    output cpu_addr_t cpu_addr_o,
    output logic      cpu_addr_oe_o,
    input  data_t     cpu_data_i,   // Shared with the SRAM
    output data_t     cpu_data_o,
    output logic      cpu_data_oe_o,

    // SRAM
    output ram_addr_t ram_addr_o,
    output logic      ram_oe_o,
    output logic      ram_we_o,

    // I/O
    output logic      io_oe_o,
    output logic      pia1_cs_o,
    output logic      pia2_cs_o,
    output logic      via_cs_o
);

    region_e region;
    logic    wb_grant;
    logic    cpu_ram_oe;
    logic    cpu_ram_we;
    logic    io_valid;

    ram_bus_if ram_bus ();

    assign ram_bus.rdata = cpu_data_i;      // Data bus read back from the pins

    address_decoder u_decoder (
        .addr_i   (cpu_addr_i),
        .region_o (region)
    );

    bus_slot_sequencer u_sequencer (
        .wb_clock_i   (wb_clock_i),
        .rst_n_i      (rst_n_i),
        .region_i     (region),
        .cpu_we_i     (cpu_we_i),
        .cpu_be_o     (cpu_be_o),
        .cpu_clock_o  (cpu_clock_o),
        .wb_grant_o   (wb_grant),
        .addr_oe_o    (cpu_addr_oe_o),
        .cpu_ram_oe_o (cpu_ram_oe),
        .cpu_ram_we_o (cpu_ram_we),
        .io_oe_o      (io_oe_o),
        .io_valid_o   (io_valid)
    );

    wb_ram_port u_wb_port (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .wb_addr_i   (wb_addr_i),
        .wb_data_i   (wb_data_i),
        .wb_data_o   (wb_data_o),
        .wb_we_i     (wb_we_i),
        .wb_cycle_i  (wb_cycle_i),
        .wb_strobe_i (wb_strobe_i),
        .wb_stall_o  (wb_stall_o),
        .wb_ack_o    (wb_ack_o),
        .grant_i     (wb_grant),
        .ram         (ram_bus.port)
    );

    // Peers never overlap, so the strobes simply merge
    assign ram_oe_o = cpu_ram_oe || ram_bus.oe;
    assign ram_we_o = cpu_ram_we || ram_bus.we;

    // CPU owns the SRAM address while BE is high, upper bank unused
    assign ram_addr_o    = cpu_be_o ? ram_addr_t'(cpu_addr_i) : ram_bus.addr;
    assign cpu_addr_o    = cpu_addr_t'(ram_bus.addr);
    assign cpu_data_o    = ram_bus.wdata;
    assign cpu_data_oe_o = ram_bus.data_oe;

    assign pia1_cs_o = io_valid && (region == PIA1);
    assign pia2_cs_o = io_valid && (region == PIA2);
    assign via_cs_o  = io_valid && (region == VIA);

endmodule

`default_nettype wire

// File: hdl/ram_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Wishbone side of the shared SRAM bus
interface ram_bus_if
    import pet_bus_pkg::*;
();

    ram_addr_t addr;        // SRAM address from the Wishbone port
    data_t     wdata;       // Write byte, also out on the CPU data bus
    data_t     rdata;       // Shared data bus as seen at the pins
    logic      oe;          // SRAM read strobe
    logic      we;          // SRAM write strobe
    logic      data_oe;     // FPGA drives the data bus

    // Wishbone port side
    modport port (
        output addr, wdata, oe, we, data_oe,
        input  rdata
    );

    // Pin side in the top level
    modport pins (
        input  addr, wdata, oe, we, data_oe,
        output rdata
    );

endinterface

`default_nettype wire

// File: hdl/wb_ram_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_settings.svh"

module wb_ram_port
    import pet_bus_pkg::*;
    import pet_seq_pkg::*;
(
    input  logic      wb_clock_i,
    input  logic      rst_n_i,
    input  ram_addr_t wb_addr_i,
    input  data_t     wb_data_i,
    output data_t     wb_data_o,
    input  logic      wb_we_i,
    input  logic      wb_cycle_i,
    input  logic      wb_strobe_i,
    output logic      wb_stall_o,
    output logic      wb_ack_o,
    input  logic      grant_i,      // Slot window open to Wishbone
    ram_bus_if.port   ram
);

    // SRAM strobes take all but the ack clock
    localparam int              CNT_W       = $clog2(`WB_LATENCY);
    localparam logic [CNT_W-1:0] ACCESS_LAST = CNT_W'(`WB_LATENCY - 2);

    wb_state_e        state;
    logic [CNT_W-1:0] access_cnt;
    logic             we_q;         // Write cycle in flight
    ram_addr_t        addr_q;
    data_t            data_q;
    logic             accept;
    logic             last;         // Final strobe clock

    assign wb_stall_o = !grant_i || (state != IDLE);    // One cycle at a time
    assign accept     = wb_cycle_i && wb_strobe_i && !wb_stall_o;
    assign last       = (state == ACCESS) && (access_cnt == ACCESS_LAST);

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= IDLE;
            access_cnt <= '0;
            we_q       <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state      <= ACCESS;
                        access_cnt <= '0;
                        we_q       <= wb_we_i;
                    end
                end
                ACCESS: begin
                    if (last) begin
                        state <= ACK;
                    end else begin
                        access_cnt <= access_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;         // ACK lasts one clock
            endcase
        end
    end

    // Request payload and read data
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            addr_q <= wb_addr_i;
            data_q <= wb_data_i;
        end
        if (last && !we_q) begin
            wb_data_o <= ram.rdata;     // SRAM output settled by now
        end
    end

    assign ram.addr    = addr_q;
    assign ram.wdata   = data_q;
    assign ram.oe      = (state == ACCESS) && !we_q;
    assign ram.data_oe = (state == ACCESS) && we_q;
    assign ram.we      = last && we_q;  // Data already on the bus a clock
    assign wb_ack_o    = (state == ACK);

endmodule

`default_nettype wire

// File: include/pet_settings.svh
`ifndef PET_SETTINGS_SVH
`define PET_SETTINGS_SVH

// Bus widths
`define CPU_ADDR_W 16              // 6502 address bus
`define RAM_ADDR_W 17              // 128K SRAM
`define DATA_W     8

// One CPU cycle per slot, Phi2 pulses once per slot
`define SLOT_CYCLES 64

// Wishbone accept to ack, also the drain before the CPU owns the bus
`define WB_LATENCY 3

// Window edges, as slot counter values
`define BE_START   (`WB_LATENCY)   // Last Wishbone cycle has drained
`define BUS_VALID  6               // CPU drives ADDR, RWB and DOUT
`define IO_VALID   8               // SRAM access and transceiver delay met
`define PHI_START  10              // CPU data setup met
`define PHI_END    15              // Minimum Phi2 high time met
`define BE_END     17              // CPU and I/O hold met
`define WB_ADDR_OE 20              // CPU is off the address bus
`define WB_READY   21              // Wishbone may start again

// Grant closes at count 0, so a cycle accepted there still ends
// at `BE_START and never meets the CPU window

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PET bus core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_pet_system -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pet_system > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
exit 0

// File: verif/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

// Asynchronous 128K x 8 SRAM on the shared data bus
module sram_model
    import pet_bus_pkg::*;
(
    input  logic      clk_i,        // Only used to sample the write strobe
    input  ram_addr_t addr_i,
    input  data_t     data_i,       // Shared data bus as seen at the pins
    output data_t     data_o,
    input  logic      oe_i,
    input  logic      we_i
);

    data_t mem [0:2**$bits(ram_addr_t)-1];

    // Fill folds every address bit into the byte
    initial begin
        for (int a = 0; a < 2**$bits(ram_addr_t); a++) begin
            mem[a] = data_t'(a) ^ data_t'(a >> 8) ^ data_t'(a >> 16);
        end
    end

    // Strobes, address and data only move on the rising edge
    always @(negedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= data_i;
        end
    end

    assign data_o = oe_i ? mem[addr_i] : '0;    // Read is combinational

endmodule

`default_nettype wire

// File: verif/tb_pet_system.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_settings.svh"

module tb_pet_system
    import pet_bus_pkg::*;
();

    localparam int N_WB       = 16;     // Random Wishbone writes
    localparam int N_DECODE   = 20;     // Random CPU cycles
    localparam int N_RAM_WR   = 4;
    localparam int N_ROM_WR   = 2;
    localparam int MAX_CYCLES = 60 * `SLOT_CYCLES + 200;

    logic      wb_clock_i;
    logic      rst_n_i;
    ram_addr_t wb_addr_i;
    data_t     wb_data_i;
    data_t     wb_data_o;
    logic      wb_we_i, wb_cycle_i, wb_strobe_i;
    logic      wb_stall_o, wb_ack_o;
    logic      cpu_be_o, cpu_clock_o, cpu_we_i;
    cpu_addr_t cpu_addr_i, cpu_addr_o;
    logic      cpu_addr_oe_o;
    data_t     cpu_data_i, cpu_data_o;
    logic      cpu_data_oe_o;
    ram_addr_t ram_addr_o;
    logic      ram_oe_o, ram_we_o;
    logic      io_oe_o, pia1_cs_o, pia2_cs_o, via_cs_o;
    data_t     cpu_wdata;               // Byte the TB CPU puts out on a write
    data_t     sram_data;

    data_t     shadow [ram_addr_t];     // Expected SRAM bytes, where known
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    int        phi_rises = 0;
    int        phi_len = 0;
    int        last_rise = 0;
    logic      prev_phi = 1'b0;
    logic      prev_be = 1'b0;
    region_e   exp_region;

    // SRAM first, then the FPGA, then the CPU write data
    assign cpu_data_i = ram_oe_o ? sram_data :
                        cpu_data_oe_o ? cpu_data_o :
                        (cpu_be_o && cpu_we_i) ? cpu_wdata : 8'h00;

    pet_system UUT (.*);

    sram_model u_sram (
        .clk_i  (wb_clock_i),
        .addr_i (ram_addr_o),
        .data_i (cpu_data_i),
        .data_o (sram_data),
        .oe_i   (ram_oe_o),
        .we_i   (ram_we_o)
    );

    always #4 wb_clock_i = ~wb_clock_i;     // 8 ns period

    // PET memory map as the CPU sees it
    function automatic region_e region_of(input cpu_addr_t a);
        if (a >= 16'he810 && a <= 16'he813) return PIA1;
        else if (a >= 16'he820 && a <= 16'he823) return PIA2;
        else if (a >= 16'he840 && a <= 16'he84f) return VIA;
        else if (a >= 16'he800 && a <= 16'he8ff) return IO_OTHER;
        else if (a <= 16'h8fff) return RAM;
        else return ROM;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got %0h exp %0h", name, got, exp);
        end
    endtask

    // One pipelined Wishbone transfer, holds the request through the stall
    task automatic wb_access(input logic we, input ram_addr_t addr, input data_t wdata,
                             output data_t rdata);
        int lat;
        @(posedge wb_clock_i);
        wb_cycle_i  <= 1'b1;
        wb_strobe_i <= 1'b1;
        wb_we_i     <= we;
        wb_addr_i   <= addr;
        wb_data_i   <= wdata;
        @(negedge wb_clock_i);
        while (wb_stall_o) begin
            @(negedge wb_clock_i);
        end
        @(posedge wb_clock_i);              // Accept edge
        wb_strobe_i <= 1'b0;
        lat = 0;
        do begin
            @(negedge wb_clock_i);
            lat++;
        end while (!wb_ack_o);
        check("wb_ack_o latency", lat, `WB_LATENCY);
        check("cpu_addr_oe_o", cpu_addr_oe_o, 1);   // Ack lands before BE_START
        check("cpu_addr_o", cpu_addr_o, cpu_addr_t'(addr));
        check("ram_addr_o", ram_addr_o, addr);     // Wishbone still owns the SRAM
        rdata = wb_data_o;                  // Valid with the ack
        if (we) begin
            shadow[addr] = wdata;
        end
        @(posedge wb_clock_i);
        wb_cycle_i <= 1'b0;
    endtask

    // Reads back every known byte over Wishbone
    task automatic verify_shadow();
        data_t got;
        foreach (shadow[a]) begin
            wb_access(1'b0, a, 8'h00, got);
            check("wb_data_o", got, shadow[a]);
        end
    endtask

    // One CPU bus cycle, set up while the Wishbone side holds the grant
    task automatic cpu_cycle(input cpu_addr_t addr, input logic we, input data_t wdata);
        @(negedge wb_clock_i);
        while (cpu_be_o || wb_stall_o) begin
            @(negedge wb_clock_i);
        end
        @(posedge wb_clock_i);
        cpu_addr_i <= addr;
        cpu_we_i   <= we;
        cpu_wdata  <= wdata;
        @(negedge wb_clock_i);
        while (!cpu_be_o) begin             // Window opens
            @(negedge wb_clock_i);
        end
        while (cpu_be_o) begin              // and closes
            @(negedge wb_clock_i);
        end
        if (we && region_of(addr) == RAM) begin
            shadow[ram_addr_t'(addr)] = wdata;  // ROM image stays as it was
        end
        @(posedge wb_clock_i);
        cpu_we_i <= 1'b0;                   // Park on reads
    endtask

    // CPU side against region_of, and Phi2 shape, on every falling edge
    always @(negedge wb_clock_i) begin
        exp_region = region_of(cpu_addr_i);
        if (wb_cycle_i && wb_strobe_i && !wb_stall_o) begin
            check("cpu_be_o", cpu_be_o, 0);     // Accept lands on the next edge
            check("cpu_addr_oe_o", cpu_addr_oe_o, 1);
        end
        if (cpu_clock_o) begin
            phi_len++;
            check("cpu_addr_oe_o", cpu_addr_oe_o, 0);   // CPU drives the address
            check("pia1_cs_o", pia1_cs_o, exp_region == PIA1);
            check("pia2_cs_o", pia2_cs_o, exp_region == PIA2);
            check("via_cs_o", via_cs_o, exp_region == VIA);
            check("io_oe_o", io_oe_o, !(exp_region inside {RAM, ROM}));
            check("ram_we_o", ram_we_o, cpu_we_i && exp_region == RAM);
            check("ram_oe_o", ram_oe_o, !cpu_we_i && (exp_region inside {RAM, ROM}));
        end else if (!cpu_be_o) begin
            check("pia1_cs_o", pia1_cs_o, 0);
            check("pia2_cs_o", pia2_cs_o, 0);
            check("via_cs_o", via_cs_o, 0);
            check("io_oe_o", io_oe_o, 0);
        end
        if (cpu_clock_o && !prev_phi) begin
            check("cpu_be_o", prev_be, 1);      // BE leads Phi2
            if (phi_rises > 0) begin
                check("cpu_clock_o period", cycles - last_rise, `SLOT_CYCLES);
            end
            last_rise = cycles;
            phi_rises++;
        end
        if (!cpu_clock_o && prev_phi) begin
            check("cpu_clock_o high clocks", phi_len, `PHI_END - `PHI_START);
            check("cpu_be_o", cpu_be_o, 1);     // and trails it
            phi_len = 0;
        end
        prev_phi = cpu_clock_o;
        prev_be  = cpu_be_o;
    end

    always @(posedge wb_clock_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d clocks, the tests did not finish", cycles);
            $display("Checks %0d, errors %0d", checks, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        data_t     rd;
        data_t     val;
        cpu_addr_t caddr;
        wb_clock_i  = 1'b0;
        rst_n_i     = 1'b0;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        wb_we_i     = 1'b0;
        wb_cycle_i  = 1'b0;
        wb_strobe_i = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata   = '0;
        void'($urandom(32'ha026788e));

        @(negedge wb_clock_i);              // One clock into reset
        check("cpu_clock_o", cpu_clock_o, 0);
        check("cpu_be_o", cpu_be_o, 0);
        check("ram_we_o", ram_we_o, 0);
        check("ram_oe_o", ram_oe_o, 0);
        check("pia1_cs_o", pia1_cs_o, 0);
        check("pia2_cs_o", pia2_cs_o, 0);
        check("via_cs_o", via_cs_o, 0);
        check("io_oe_o", io_oe_o, 0);
        check("wb_ack_o", wb_ack_o, 0);
        check("cpu_data_oe_o", cpu_data_oe_o, 0);
        repeat (2) @(posedge wb_clock_i);
        rst_n_i <= 1'b1;
        repeat (`WB_READY) begin            // Grant still closed
            @(negedge wb_clock_i);
            check("wb_stall_o", wb_stall_o, 1);
        end

        for (int i = 0; i < N_WB; i++) begin
            wb_access(1'b1, ram_addr_t'($urandom), data_t'($urandom), rd);
        end
        verify_shadow();

        for (int i = 0; i < N_DECODE; i++) begin
            caddr = cpu_addr_t'($urandom);
            if ($urandom % 2 == 0) begin
                caddr[15:8] = 8'he8;        // Half of them in the I/O page
            end
            cpu_cycle(caddr, 1'($urandom), data_t'($urandom));
        end

        for (int i = 0; i < N_RAM_WR; i++) begin
            cpu_cycle(cpu_addr_t'($urandom % 32'h9000), 1'b1, data_t'($urandom));
        end
        for (int i = 0; i < N_ROM_WR; i++) begin
            do begin
                caddr = 16'h9000 + cpu_addr_t'($urandom % 32'h7000);
            end while (region_of(caddr) != ROM);
            val = data_t'($urandom);
            wb_access(1'b1, ram_addr_t'(caddr), val, rd);
            cpu_cycle(caddr, 1'b1, ~val);   // Must bounce off the ROM image
        end
        verify_shadow();

        if (phi_rises == 0) begin
            errors++;
            $display("No Phi2 pulse was seen on cpu_clock_o");
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
